// File: rtl/gat_consts.svh
/*
 * GAT feature transform sizes
 * Matrix shapes, data widths and memory depths of the WH core
 */

`ifndef GAT_CONSTS_SVH
`define GAT_CONSTS_SVH

// ========================================
// Base sizes
// ========================================
`define GAT_DATA_WIDTH          8
`define GAT_NUM_FEATURE_IN      11
`define GAT_NUM_FEATURE_OUT     4
`define GAT_TOTAL_NODES         16
`define GAT_H_NUM_SPARSE_DATA   64
`define GAT_ACC_WIDTH           20
`define GAT_FEAT_WIDTH          32

// ========================================
// Derived widths and depths
// ========================================
`define GAT_COL_IDX_WIDTH       ($clog2(`GAT_NUM_FEATURE_IN))
`define GAT_H_DATA_WIDTH        (`GAT_DATA_WIDTH + `GAT_COL_IDX_WIDTH)
`define GAT_H_ADDR_WIDTH        ($clog2(`GAT_H_NUM_SPARSE_DATA))
// Row length counts 0 to NUM_FEATURE_IN inclusive
`define GAT_ROW_LEN_WIDTH       ($clog2(`GAT_NUM_FEATURE_IN + 1))
`define GAT_NODE_IDX_WIDTH      ($clog2(`GAT_TOTAL_NODES))
`define GAT_FEAT_DEPTH          (`GAT_TOTAL_NODES * `GAT_NUM_FEATURE_OUT)
`define GAT_FEAT_ADDR_WIDTH     ($clog2(`GAT_FEAT_DEPTH))

`endif

// File: rtl/gat_pkg.sv
/*
 * GAT core types
 * Named vectors for H values, indices, addresses, weight rows
 * and accumulated WH results
 */

`default_nettype none

`include "gat_consts.svh"

package gat_pkg;

  // H matrix
  typedef logic signed [`GAT_DATA_WIDTH-1:0]      h_value_t;
  typedef logic        [`GAT_COL_IDX_WIDTH-1:0]   col_idx_t;
  // Value in the upper bits, column index below
  typedef logic        [`GAT_H_DATA_WIDTH-1:0]    h_data_t;
  typedef logic        [`GAT_H_ADDR_WIDTH-1:0]    h_addr_t;
  typedef logic        [`GAT_ROW_LEN_WIDTH-1:0]   row_len_t;
  typedef logic        [`GAT_NODE_IDX_WIDTH-1:0]  node_idx_t;

  // One W row, feature f in byte f
  typedef logic [`GAT_NUM_FEATURE_OUT-1:0][`GAT_DATA_WIDTH-1:0] wgt_row_t;

  // WH results
  typedef logic signed [`GAT_ACC_WIDTH-1:0]       acc_t;
  typedef acc_t        [`GAT_NUM_FEATURE_OUT-1:0] wh_row_t;

  typedef logic        [`GAT_FEAT_ADDR_WIDTH-1:0] feat_addr_t;
  typedef logic        [`GAT_FEAT_WIDTH-1:0]      feat_data_t;

endpackage

`default_nettype wire

// File: rtl/gat_bram.sv
/*
 * Simple dual-port block memory
 * Port A writes, port B reads through an output register
 */

`timescale 1ns/100ps
`default_nettype none

module gat_bram #(
  parameter int DATA_WIDTH = 8,
  parameter int DEPTH      = 64,
  localparam int ADDR_W    = $clog2(DEPTH)
) (
  input  logic                  clk,
  input  logic                  ena,
  input  logic                  wea,
  input  logic [ADDR_W-1:0]     addra,
  input  logic [DATA_WIDTH-1:0] din,
  input  logic [ADDR_W-1:0]     addrb,
  output logic [DATA_WIDTH-1:0] dout
);

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (ena && wea) begin
      mem[addra] <= din;
    end
  end

  // One cycle read latency
  always_ff @(posedge clk) begin
    dout <= mem[addrb];
  end

endmodule

`default_nettype wire

// File: rtl/spmm_scheduler.sv
/*
 * Sparse H row scheduler
 * Walks the nodes in order, fetches each row length and issues one
 * H data read per nonzero. Waits for the feature writer between rows
 * and raises gat_ready once the last row is stored
 */

`timescale 1ns/100ps
`default_nettype none

`include "gat_consts.svh"

module spmm_scheduler (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               h_data_bram_load_done,
  input  logic               h_node_info_bram_load_done,
  input  logic               wgt_bram_load_done,
  output gat_pkg::node_idx_t node_info_addrb,
  input  gat_pkg::row_len_t  node_info_dout,
  output gat_pkg::h_addr_t   h_data_addrb,
  output logic               h_rd,
  output logic               row_last,
  output logic               row_empty,
  input  logic               feat_done,
  output logic               gat_ready
);

  import gat_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_INFO,
    S_ISSUE,
    S_WAIT,
    S_DONE
  } state_t;

  state_t    state;
  node_idx_t node_cnt;
  h_addr_t   h_ptr;
  row_len_t  rem_cnt;
  logic      all_loaded;
  logic      last_node;

  assign all_loaded = h_data_bram_load_done & h_node_info_bram_load_done &
                      wgt_bram_load_done;
  assign last_node  = (node_cnt == node_idx_t'(`GAT_TOTAL_NODES - 1));

  // Look one node ahead while waiting, so the row length is ready in S_INFO
  assign node_info_addrb = (state == S_WAIT) ? node_idx_t'(node_cnt + 1'b1) : node_cnt;

  assign h_data_addrb = h_ptr;
  assign h_rd         = (state == S_ISSUE);
  assign row_last     = (state == S_ISSUE) && (rem_cnt == row_len_t'(1));
  assign row_empty    = (state == S_INFO) && (node_info_dout == '0);

  // ========================================
  // Control FSM
  // ========================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      node_cnt  <= '0;
      h_ptr     <= '0;
      rem_cnt   <= '0;
      gat_ready <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (all_loaded) begin
            state <= S_INFO;
          end
        end
        S_INFO: begin
          rem_cnt <= node_info_dout;
          state   <= (node_info_dout == '0) ? S_WAIT : S_ISSUE;
        end
        S_ISSUE: begin
          // H pointer keeps running across rows
          h_ptr   <= h_ptr + 1'b1;
          rem_cnt <= rem_cnt - 1'b1;
          if (rem_cnt == row_len_t'(1)) begin
            state <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (feat_done) begin
            if (last_node) begin
              state     <= S_DONE;
              gat_ready <= 1'b1;
            end else begin
              node_cnt <= node_cnt + 1'b1;
              state    <= S_INFO;
            end
          end
        end
        // Terminal until the next reset
        S_DONE: begin
          gat_ready <= 1'b1;
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/wh_accumulator.sv
/*
 * WH row accumulator
 * Reads the W row addressed by each H column and adds value times
 * weight into one accumulator per output feature. Emits the row
 * after its last product, or right away for an empty row
 */

`timescale 1ns/100ps
`default_nettype none

`include "gat_consts.svh"

module wh_accumulator (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              h_rd,
  input  logic              row_last,
  input  logic              row_empty,
  input  gat_pkg::h_data_t  h_data_dout,
  output gat_pkg::col_idx_t wgt_addrb,
  input  gat_pkg::wgt_row_t wgt_dout,
  output logic              row_valid,
  output gat_pkg::wh_row_t  wh_row
);

  import gat_pkg::*;

  localparam int NF = `GAT_NUM_FEATURE_OUT;
  localparam int DW = `GAT_DATA_WIDTH;
  localparam int CW = $bits(col_idx_t);
  localparam int HW = $bits(h_data_t);

  logic     rd_d;
  logic     last_d;
  logic     empty_d;
  logic     s1_vld;
  logic     s1_last;
  logic     s1_empty;
  h_value_t s1_val;
  wh_row_t  acc;
  wh_row_t  acc_nxt;

  // Weight row comes straight from the H column
  assign wgt_addrb = h_data_dout[CW-1:0];
  assign wh_row    = acc;

  // ========================================
  // Flag pipeline
  // ========================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_d      <= 1'b0;
      last_d    <= 1'b0;
      empty_d   <= 1'b0;
      s1_vld    <= 1'b0;
      s1_last   <= 1'b0;
      s1_empty  <= 1'b0;
      row_valid <= 1'b0;
      acc       <= '0;
    end else begin
      // Align with H data dout
      rd_d      <= h_rd;
      last_d    <= row_last;
      empty_d   <= row_empty;
      s1_vld    <= rd_d;
      s1_last   <= last_d;
      s1_empty  <= empty_d;
      row_valid <= (s1_vld & s1_last) | s1_empty;
      acc       <= acc_nxt;
    end
  end

  // Value waits here while the weight row is read
  always_ff @(posedge clk) begin
    if (rd_d) begin
      s1_val <= h_value_t'(h_data_dout[HW-1 -: DW]);
    end
  end

  // Clear after an emitted row, then add this cycle's products
  always_comb begin
    for (int f = 0; f < NF; f++) begin
      acc_nxt[f] = row_valid ? acc_t'(0) : acc[f];
      if (s1_vld) begin
        acc_nxt[f] = acc_nxt[f] + acc_t'(s1_val) * acc_t'(h_value_t'(wgt_dout[f]));
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/feat_writer.sv
/*
 * Feature memory writer
 * Latches one WH row and writes its features, sign-extended,
 * to consecutive addresses of the node, one word per cycle
 */

`timescale 1ns/100ps
`default_nettype none

`include "gat_consts.svh"

module feat_writer (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                row_valid,
  input  gat_pkg::wh_row_t    wh_row,
  output logic                feat_ena,
  output gat_pkg::feat_addr_t feat_addra,
  output gat_pkg::feat_data_t feat_din,
  output logic                feat_done
);

  import gat_pkg::*;

  localparam int NF  = `GAT_NUM_FEATURE_OUT;
  localparam int AW  = `GAT_ACC_WIDTH;
  localparam int FW  = `GAT_FEAT_WIDTH;
  localparam int FIW = $clog2(NF);

  logic           busy;
  logic [FIW-1:0] f_idx;
  node_idx_t      node_cnt;
  wh_row_t        row_q;
  acc_t           cur_acc;

  assign cur_acc    = row_q[f_idx];
  assign feat_ena   = busy;
  // Address is node * NUM_FEATURE_OUT + feature
  assign feat_addra = feat_addr_t'(node_cnt) * feat_addr_t'(NF) + feat_addr_t'(f_idx);
  assign feat_din   = {{(FW - AW){cur_acc[AW-1]}}, cur_acc};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      f_idx     <= '0;
      node_cnt  <= '0;
      feat_done <= 1'b0;
    end else begin
      feat_done <= 1'b0;
      if (!busy) begin
        if (row_valid) begin
          busy  <= 1'b1;
          f_idx <= '0;
        end
      end else if (f_idx == FIW'(NF - 1)) begin
        busy      <= 1'b0;
        f_idx     <= '0;
        node_cnt  <= node_cnt + 1'b1;
        feat_done <= 1'b1;
      end else begin
        f_idx <= f_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (row_valid && !busy) begin
      row_q <= wh_row;
    end
  end

endmodule

`default_nettype wire

// File: rtl/gat_top.sv
/*
 * GAT feature transform core
 * Host-loaded H and W memories feed a sparse WH pipeline whose rows
 * land in the feature memory, readable by the host on port B
 */

`timescale 1ns/100ps
`default_nettype none

`include "gat_consts.svh"

module gat_top (
  input  logic                clk,
  input  logic                rst_n,

  input  logic                h_data_bram_load_done,
  input  logic                h_node_info_bram_load_done,
  input  logic                wgt_bram_load_done,
  output logic                gat_ready,

  input  gat_pkg::h_data_t    h_data_bram_din,
  input  logic                h_data_bram_ena,
  input  logic                h_data_bram_wea,
  input  gat_pkg::h_addr_t    h_data_bram_addra,

  input  gat_pkg::row_len_t   h_node_info_bram_din,
  input  logic                h_node_info_bram_ena,
  input  logic                h_node_info_bram_wea,
  input  gat_pkg::node_idx_t  h_node_info_bram_addra,

  input  gat_pkg::wgt_row_t   wgt_bram_din,
  input  logic                wgt_bram_ena,
  input  logic                wgt_bram_wea,
  input  gat_pkg::col_idx_t   wgt_bram_addra,

  input  gat_pkg::feat_addr_t feat_bram_addrb,
  output gat_pkg::feat_data_t feat_bram_dout
);

  import gat_pkg::*;

  h_addr_t    h_data_addrb;
  h_data_t    h_data_dout;
  node_idx_t  node_info_addrb;
  row_len_t   node_info_dout;
  col_idx_t   wgt_addrb;
  wgt_row_t   wgt_dout;

  logic       h_rd;
  logic       row_last;
  logic       row_empty;
  logic       row_valid;
  wh_row_t    wh_row;

  logic       feat_ena;
  feat_addr_t feat_addra;
  feat_data_t feat_din;
  logic       feat_done;

  // ========================================
  // Memories
  // ========================================
  gat_bram #(
    .DATA_WIDTH ($bits(h_data_t)),
    .DEPTH      (`GAT_H_NUM_SPARSE_DATA)
  ) u_h_data_bram (
    .clk   (clk),
    .ena   (h_data_bram_ena),
    .wea   (h_data_bram_wea),
    .addra (h_data_bram_addra),
    .din   (h_data_bram_din),
    .addrb (h_data_addrb),
    .dout  (h_data_dout)
  );

  gat_bram #(
    .DATA_WIDTH ($bits(row_len_t)),
    .DEPTH      (`GAT_TOTAL_NODES)
  ) u_h_node_info_bram (
    .clk   (clk),
    .ena   (h_node_info_bram_ena),
    .wea   (h_node_info_bram_wea),
    .addra (h_node_info_bram_addra),
    .din   (h_node_info_bram_din),
    .addrb (node_info_addrb),
    .dout  (node_info_dout)
  );

  gat_bram #(
    .DATA_WIDTH ($bits(wgt_row_t)),
    .DEPTH      (`GAT_NUM_FEATURE_IN)
  ) u_wgt_bram (
    .clk   (clk),
    .ena   (wgt_bram_ena),
    .wea   (wgt_bram_wea),
    .addra (wgt_bram_addra),
    .din   (wgt_bram_din),
    .addrb (wgt_addrb),
    .dout  (wgt_dout)
  );

  gat_bram #(
    .DATA_WIDTH ($bits(feat_data_t)),
    .DEPTH      (`GAT_FEAT_DEPTH)
  ) u_feat_bram (
    .clk   (clk),
    .ena   (feat_ena),
    .wea   (feat_ena),
    .addra (feat_addra),
    .din   (feat_din),
    .addrb (feat_bram_addrb),
    .dout  (feat_bram_dout)
  );

  // ========================================
  // Compute chain
  // ========================================
  spmm_scheduler u_spmm_scheduler (
    .clk                        (clk),
    .rst_n                      (rst_n),
    .h_data_bram_load_done      (h_data_bram_load_done),
    .h_node_info_bram_load_done (h_node_info_bram_load_done),
    .wgt_bram_load_done         (wgt_bram_load_done),
    .node_info_addrb            (node_info_addrb),
    .node_info_dout             (node_info_dout),
    .h_data_addrb               (h_data_addrb),
    .h_rd                       (h_rd),
    .row_last                   (row_last),
    .row_empty                  (row_empty),
    .feat_done                  (feat_done),
    .gat_ready                  (gat_ready)
  );

  wh_accumulator u_wh_accumulator (
    .clk         (clk),
    .rst_n       (rst_n),
    .h_rd        (h_rd),
    .row_last    (row_last),
    .row_empty   (row_empty),
    .h_data_dout (h_data_dout),
    .wgt_addrb   (wgt_addrb),
    .wgt_dout    (wgt_dout),
    .row_valid   (row_valid),
    .wh_row      (wh_row)
  );

  feat_writer u_feat_writer (
    .clk        (clk),
    .rst_n      (rst_n),
    .row_valid  (row_valid),
    .wh_row     (wh_row),
    .feat_ena   (feat_ena),
    .feat_addra (feat_addra),
    .feat_din   (feat_din),
    .feat_done  (feat_done)
  );

endmodule

`default_nettype wire

// File: tests/gat_top_properties.sv
/*
 * Protocol properties of the GAT core
 * Bound into gat_top, watches the ready level, feature writes
 * and the scheduler strobes
 */

`timescale 1ns/100ps
`default_nettype none

module gat_top_properties (
  input logic clk,
  input logic rst_n,
  input logic gat_ready,
  input logic feat_ena,
  input logic h_rd,
  input logic row_empty
);

  int unsigned assert_fail_count = 0;

  // Ready drops only through a sampled reset
  ready_held: assert property (@(posedge clk) (rst_n && gat_ready) |=> gat_ready)
    else begin
      $error("gat_ready fell without a reset");
      assert_fail_count++;
    end

  // Run is over once ready is up
  no_write_after_ready: assert property (
    @(posedge clk) disable iff (!rst_n) gat_ready |-> !feat_ena)
    else begin
      $error("feature write while gat_ready is high");
      assert_fail_count++;
    end

  strobes_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(h_rd && row_empty))
    else begin
      $error("h_rd and row_empty high together");
      assert_fail_count++;
    end

endmodule

bind gat_top gat_top_properties u_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .gat_ready (gat_ready),
  .feat_ena  (feat_ena),
  .h_rd      (h_rd),
  .row_empty (row_empty)
);

`default_nettype wire

// File: tests/gat_top_tb.sv
/*
 * Testbench for the GAT feature transform core
 * Loads a random sparse H and a random W, runs the core twice with
 * a reset in between and checks every feature word against a model
 */

`timescale 1ns/100ps
`default_nettype none

`include "gat_consts.svh"

module gat_top_tb;

  import gat_pkg::*;

  localparam int NODES         = `GAT_TOTAL_NODES;
  localparam int FIN           = `GAT_NUM_FEATURE_IN;
  localparam int FOUT          = `GAT_NUM_FEATURE_OUT;
  localparam int NNZ_MAX       = `GAT_H_NUM_SPARSE_DATA;
  localparam int FDEPTH        = `GAT_FEAT_DEPTH;
  localparam int READY_TIMEOUT = 4000;
  // Longer than a whole run, so an early start would show on gat_ready
  localparam int HOLD_MIN      = NODES * 16 + NNZ_MAX;

  logic       clk;
  logic       rst_n;
  logic       h_data_bram_load_done;
  logic       h_node_info_bram_load_done;
  logic       wgt_bram_load_done;
  logic       gat_ready;
  h_data_t    h_data_bram_din;
  logic       h_data_bram_ena;
  logic       h_data_bram_wea;
  h_addr_t    h_data_bram_addra;
  row_len_t   h_node_info_bram_din;
  logic       h_node_info_bram_ena;
  logic       h_node_info_bram_wea;
  node_idx_t  h_node_info_bram_addra;
  wgt_row_t   wgt_bram_din;
  logic       wgt_bram_ena;
  logic       wgt_bram_wea;
  col_idx_t   wgt_bram_addra;
  feat_addr_t feat_bram_addrb;
  feat_data_t feat_bram_dout;

  int row_len [NODES];
  int h_val [NNZ_MAX];
  int h_col [NNZ_MAX];
  int w [FIN][FOUT];
  int expected [FDEPTH];
  int nnz_total;
  int checks;
  int errors;
  bit timed_out;

  gat_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic compare(string name, logic [31:0] actual, logic [31:0] exp);
    checks++;
    assert (actual === exp) else begin
      errors++;
      $display("FAILED t=%0t %s actual=%0h expected=%0h", $time, name, actual, exp);
    end
  endtask

  task automatic apply_reset();
    rst_n                      = 1'b0;
    h_data_bram_load_done      = 1'b0;
    h_node_info_bram_load_done = 1'b0;
    wgt_bram_load_done         = 1'b0;
    next_cycle();
    next_cycle();
    rst_n = 1'b1;
    compare("gat_ready", gat_ready, 1'b0);
  endtask

  // Random sparse H with empty first and last rows, random W, model of WH
  task automatic build_matrices();
    int budget;
    int need;
    int ptr;
    int v;
    budget = NNZ_MAX;
    ptr    = 0;
    for (int n = 0; n < NODES; n++) begin
      need = $urandom_range(0, FIN);
      if (n == 0 || n == NODES - 1) begin
        need = 0;
      end
      if (need > budget) begin
        need = budget;
      end
      row_len[n] = need;
      budget -= need;
      // Selection sampling keeps columns distinct and sorted
      for (int c = 0; c < FIN; c++) begin
        if ($urandom_range(0, FIN - c - 1) < need) begin
          v = $urandom_range(1, 127);
          if ($urandom_range(0, 1) == 1) begin
            v = -v;
          end
          h_col[ptr] = c;
          h_val[ptr] = v;
          need--;
          ptr++;
        end
      end
    end
    nnz_total = ptr;
    for (int c = 0; c < FIN; c++) begin
      for (int f = 0; f < FOUT; f++) begin
        w[c][f] = int'($urandom_range(0, 255)) - 128;
      end
    end
    ptr = 0;
    for (int n = 0; n < NODES; n++) begin
      for (int f = 0; f < FOUT; f++) begin
        expected[n * FOUT + f] = 0;
        for (int k = 0; k < row_len[n]; k++) begin
          expected[n * FOUT + f] += h_val[ptr + k] * w[h_col[ptr + k]][f];
        end
      end
      ptr += row_len[n];
    end
  endtask

  task automatic load_memories();
    wgt_row_t row;
    for (int i = 0; i < NNZ_MAX; i++) begin
      for (int f = 0; f < FOUT; f++) begin
        row[f] = 8'(w[i % FIN][f]);
      end
      h_data_bram_ena        = (i < nnz_total);
      h_data_bram_wea        = 1'b1;
      h_data_bram_addra      = h_addr_t'(i);
      h_data_bram_din        = {h_value_t'(h_val[i]), col_idx_t'(h_col[i])};
      h_node_info_bram_ena   = (i < NODES);
      h_node_info_bram_wea   = 1'b1;
      h_node_info_bram_addra = node_idx_t'(i);
      h_node_info_bram_din   = row_len_t'(row_len[i % NODES]);
      wgt_bram_ena           = (i < FIN);
      wgt_bram_wea           = 1'b1;
      wgt_bram_addra         = col_idx_t'(i % FIN);
      wgt_bram_din           = row;
      next_cycle();
    end
    h_data_bram_ena      = 1'b0;
    h_data_bram_wea      = 1'b0;
    h_node_info_bram_ena = 1'b0;
    h_node_info_bram_wea = 1'b0;
    wgt_bram_ena         = 1'b0;
    wgt_bram_wea         = 1'b0;
  endtask

  task automatic set_load_done(int which);
    case (which)
      0:       h_data_bram_load_done = 1'b1;
      1:       h_node_info_bram_load_done = 1'b1;
      default: wgt_bram_load_done = 1'b1;
    endcase
  endtask

  // Levels rise in a shuffled order, core must stay idle meanwhile
  task automatic raise_load_done();
    int order [3];
    int pick;
    int tmp;
    int hold;
    order = '{0, 1, 2};
    for (int i = 2; i > 0; i--) begin
      pick        = $urandom_range(0, i);
      tmp         = order[i];
      order[i]    = order[pick];
      order[pick] = tmp;
    end
    for (int i = 0; i < 3; i++) begin
      hold = $urandom_range(HOLD_MIN, HOLD_MIN + 20);
      for (int c = 0; c < hold; c++) begin
        next_cycle();
        compare("gat_ready", gat_ready, 1'b0);
      end
      set_load_done(order[i]);
    end
  endtask

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    while (gat_ready !== 1'b1 && cycles < READY_TIMEOUT) begin
      next_cycle();
      cycles++;
    end
    if (gat_ready !== 1'b1) begin
      timed_out = 1'b1;
      errors++;
      $display("Timeout: gat_ready did not rise within %0d cycles", READY_TIMEOUT);
    end
  endtask

  // Back-to-back reads, in order and then at random addresses
  task automatic read_features();
    int addr_q [$];
    for (int i = 0; i < FDEPTH; i++) begin
      addr_q.push_back(i);
    end
    for (int i = 0; i < FDEPTH / 2; i++) begin
      addr_q.push_back($urandom_range(0, FDEPTH - 1));
    end
    foreach (addr_q[i]) begin
      feat_bram_addrb = feat_addr_t'(addr_q[i]);
      next_cycle();
      compare($sformatf("feat_bram_dout[%0d]", addr_q[i]), feat_bram_dout,
              feat_data_t'(expected[addr_q[i]]));
      compare("gat_ready", gat_ready, 1'b1);
    end
  endtask

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    void'($urandom(32'h7cd7));
    rst_n                      = 1'b0;
    h_data_bram_load_done      = 1'b0;
    h_node_info_bram_load_done = 1'b0;
    wgt_bram_load_done         = 1'b0;
    h_data_bram_din            = '0;
    h_data_bram_ena            = 1'b0;
    h_data_bram_wea            = 1'b0;
    h_data_bram_addra          = '0;
    h_node_info_bram_din       = '0;
    h_node_info_bram_ena       = 1'b0;
    h_node_info_bram_wea       = 1'b0;
    h_node_info_bram_addra     = '0;
    wgt_bram_din               = '0;
    wgt_bram_ena               = 1'b0;
    wgt_bram_wea               = 1'b0;
    wgt_bram_addra             = '0;
    feat_bram_addrb            = '0;
    checks                     = 0;
    errors                     = 0;
    timed_out                  = 1'b0;

    // Two runs, the second with fresh data after a reset
    for (int run = 0; run < 2; run++) begin
      if (!timed_out) begin
        apply_reset();
        build_matrices();
        load_memories();
        raise_load_done();
        wait_ready();
        if (!timed_out) begin
          read_features();
        end
      end
    end

    $display("Checks: %0d, errors: %0d, property failures: %0d",
             checks, errors, uut.u_props.assert_fail_count);
    if (errors == 0 && uut.u_props.assert_fail_count == 0 && !timed_out) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: gat_top.f
+incdir+rtl
rtl/gat_pkg.sv
rtl/gat_bram.sv
rtl/spmm_scheduler.sv
rtl/wh_accumulator.sv
rtl/feat_writer.sv
rtl/gat_top.sv
tests/gat_top_properties.sv
tests/gat_top_tb.sv

// File: Bender.yml
package:
  name: gat_top

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/gat_pkg.sv
      - rtl/gat_bram.sv
      - rtl/spmm_scheduler.sv
      - rtl/wh_accumulator.sv
      - rtl/feat_writer.sv
      - rtl/gat_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/gat_top_properties.sv
      - tests/gat_top_tb.sv
